// ==== build.f ====
+incdir+hw
hw/apu_pkg.sv
hw/ch1_regs.sv
hw/apu_frame_seq.sv
hw/ch1_freq_sweep.sv
hw/ch1_envelope.sv
hw/ch1_output.sv
hw/apu_ch1.sv
sim/apu_ch1_assert.sv
sim/apu_ch1_tb.sv

// ==== sim/apu_ch1_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apu_settings.svh"

module apu_ch1_tb;

	localparam int NUM_ENTRIES = 8;
	localparam int LEN_PERIOD = 2 * `APU_FRAME_DIV; // clocks between length ticks
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 4 + 4 * 64 * LEN_PERIOD;
	localparam logic [7:0] RD_MASK [8] = '{8'h80, 8'h3f, 8'h00, 8'hff, 8'hbf, 8'h00, 8'h00, 8'h00};
	localparam int DUTY_EIGHTHS [4] = '{1, 2, 4, 6};

	typedef struct packed {
		logic [2:0] offset;
		logic [7:0] wdata;
		logic [7:0] exp_rd;
		logic       exp_err;
	} entry_t;

	logic              clk;
	logic              rst;
	apu_pkg::apb_req_t apb_req;
	apu_pkg::apb_rsp_t apb_rsp;
	logic [3:0]        sample;
	logic              ch1_on;
	logic [31:0]       lcg_state = 32'he80c_e9e5;
	int                cycles = 0;
	entry_t            stim [NUM_ENTRIES];

	apu_ch1 i_dut (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.sample  (sample),
		.ch1_on  (ch1_on)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		check_value("assertion_failures", i_dut.u_assert.fail_cnt, 0);
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic apb_xfer(input logic write, input logic [2:0] addr, input logic [7:0] wdata,
		output logic [7:0] rdata, output logic slverr);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		next_cycle();
		apb_req.penable = 1'b1;
		#40; // mid access phase
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		check_value("pready", apb_rsp.pready, 1'b1);
		next_cycle();
		apb_req = '0;
	endtask

	task automatic reg_write(input logic [2:0] addr, input logic [7:0] wdata);
		logic [7:0] rd;
		logic       err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		check_value("pslverr", err, 1'b0);
	endtask

	task automatic trigger_on(input logic [10:0] freq, input logic len_en, input logic exp_on);
		reg_write(`APU_ADDR_NR13, freq[7:0]);
		reg_write(`APU_ADDR_NR14, {1'b1, len_en, 3'b000, freq[10:8]});
		next_cycle(); // past the trigger pulse
		check_value("ch1_on", ch1_on, exp_on);
	endtask

	initial begin
		logic [7:0] rd;
		logic       err;
		logic [3:0] vol;
		logic [3:0] peak;
		logic [3:0] prev_peak;
		int         high_cnt;
		int         windows;
		int         fall_at;

		rst = 1'b1;
		apb_req = '0;
		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;
		check_value("ch1_on", ch1_on, 1'b0);
		check_value("sample", sample, 4'h0);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			stim[i].offset  = 3'(i);
			stim[i].wdata   = 8'(lcg_next() >> 24);
			stim[i].exp_err = i > 4;
			stim[i].exp_rd  = stim[i].exp_err ? 8'h00 : stim[i].wdata | RD_MASK[i];
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			apb_xfer(1'b1, stim[i].offset, stim[i].wdata, rd, err);
			check_value($sformatf("pslverr[%0d]", i), err, stim[i].exp_err);
			apb_xfer(1'b0, stim[i].offset, 8'h00, rd, err);
			check_value($sformatf("prdata[%0d]", i), rd, stim[i].exp_rd);
			check_value($sformatf("pslverr[%0d]", i), err, stim[i].exp_err);
		end

		// duty fraction at fixed volume
		reg_write(`APU_ADDR_NR10, 8'h00);
		for (int d = 0; d < 4; d++) begin
			vol = 4'(lcg_next() >> 28);
			if (vol == 4'h0)
				vol = 4'h1;
			reg_write(`APU_ADDR_NR11, {2'(d), 6'd0});
			reg_write(`APU_ADDR_NR12, {vol, 4'h0});
			trigger_on(11'd2047, 1'b0, 1'b1);
			high_cnt = 0;
			repeat (4) next_cycle();
			for (int s = 0; s < 64; s++) begin
				if (sample != 4'h0) begin
					check_value("sample", sample, vol);
					high_cnt++;
				end
				repeat (`APU_FREQ_PRESCALE) next_cycle(); // one duty step
			end
			check_value($sformatf("duty%0d_high_count", d), high_cnt, 8 * DUTY_EIGHTHS[d]);
		end

		// envelope falling from 15
		reg_write(`APU_ADDR_NR11, {2'd2, 6'd0});
		reg_write(`APU_ADDR_NR12, 8'hf1);
		trigger_on(11'd2047, 1'b0, 1'b1);
		prev_peak = 4'hf;
		peak = 4'hf;
		windows = 0;
		while (peak != 4'h0) begin
			peak = 4'h0;
			repeat (8 * `APU_FRAME_DIV) begin // one envelope tick period
				next_cycle();
				if (sample > peak)
					peak = sample;
			end
			check_value("peak_rise", peak > prev_peak, 1'b0);
			prev_peak = peak;
			windows++;
		end
		check_value("env_windows_ge_15", windows >= 15, 1'b1);

		// length counter, 2 ticks to expiry
		reg_write(`APU_ADDR_NR11, {2'd2, 6'd62});
		reg_write(`APU_ADDR_NR12, 8'hf0);
		trigger_on(11'd2047, 1'b1, 1'b1);
		fall_at = 0;
		for (int i = 1; i <= 5 * LEN_PERIOD; i++) begin
			next_cycle();
			if (fall_at == 0 && !ch1_on)
				fall_at = i;
			if (i >= 3 * LEN_PERIOD)
				check_value("ch1_on", ch1_on, 1'b0);
		end
		check_value("length_fall_window",
			fall_at > LEN_PERIOD - 2 && fall_at <= 2 * LEN_PERIOD + 2, 1'b1);
		trigger_on(11'd2047, 1'b0, 1'b1);
		for (int i = 1; i <= 5 * LEN_PERIOD; i++) begin
			next_cycle();
			check_value("ch1_on", ch1_on, 1'b1);
		end

		// 2000 + 1000 overflows on trigger
		reg_write(`APU_ADDR_NR10, 8'h11);
		trigger_on(11'd2000, 1'b0, 1'b0);
		repeat (LEN_PERIOD) begin
			next_cycle();
			check_value("ch1_on", ch1_on, 1'b0);
		end

		reg_write(`APU_ADDR_NR10, 8'h00);
		reg_write(`APU_ADDR_NR12, 8'h00);
		trigger_on(11'd2047, 1'b0, 1'b0);
		reg_write(`APU_ADDR_NR12, 8'hf0);
		trigger_on(11'd2047, 1'b0, 1'b1);
		reg_write(`APU_ADDR_NR12, 8'h07);
		next_cycle();
		check_value("ch1_on", ch1_on, 1'b0);
		check_value("sample", sample, 4'h0);
		check_value("assertion_failures", i_dut.u_assert.fail_cnt, 0);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/apu_ch1_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_ch1_assert (
	input wire logic              clk,
	input wire logic              rst,
	input wire apu_pkg::apb_req_t apb_req,
	input wire apu_pkg::apb_rsp_t apb_rsp,
	input wire logic              dac_en,
	input wire logic [3:0]        sample,
	input wire logic              ch1_on
);

	int fail_cnt = 0; // failed assertions so far

	apb_no_wait: assert property (@(posedge clk) disable iff (rst)
		apb_req.penable |-> apb_rsp.pready)
		else begin
			$error("pready low while penable high");
			fail_cnt++;
		end

	slverr_in_access: assert property (@(posedge clk) disable iff (rst)
		apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
		else begin
			$error("pslverr outside access phase");
			fail_cnt++;
		end

	// ch1_on is registered, so it drops one cycle after the DAC
	dac_off_silent: assert property (@(posedge clk) disable iff (rst)
		!dac_en |=> !ch1_on)
		else begin
			$error("ch1_on high with DAC disabled");
			fail_cnt++;
		end

	off_sample_zero: assert property (@(posedge clk) disable iff (rst)
		!ch1_on |-> sample == 4'h0)
		else begin
			$error("nonzero sample while channel off");
			fail_cnt++;
		end

endmodule

bind apu_ch1 apu_ch1_assert u_assert (
	.clk     (clk),
	.rst     (rst),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp),
	.dac_en  (cfg.dac_en),
	.sample  (sample),
	.ch1_on  (ch1_on)
);

`default_nettype wire

// ==== hw/apu_ch1.sv ====
`timescale 1ns/1ns
`default_nettype none

module apu_ch1 (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire apu_pkg::apb_req_t apb_req,
	output apu_pkg::apb_rsp_t      apb_rsp,
	output logic [3:0]             sample,
	output logic                   ch1_on
);

	apu_pkg::ch1_cfg_t    cfg;
	apu_pkg::frame_tick_t ticks;
	logic                 trigger;
	logic                 length_load;
	logic                 duty_bit;
	logic                 sweep_overflow;
	logic [3:0]           volume;

	ch1_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.cfg         (cfg),
		.trigger     (trigger),
		.length_load (length_load)
	);

	apu_frame_seq u_frame (
		.clk   (clk),
		.rst   (rst),
		.ticks (ticks)
	);

	ch1_freq_sweep u_freq (
		.clk            (clk),
		.rst            (rst),
		.cfg            (cfg),
		.trigger        (trigger),
		.ticks          (ticks),
		.duty_bit       (duty_bit),
		.sweep_overflow (sweep_overflow)
	);

	ch1_envelope u_env (
		.clk     (clk),
		.rst     (rst),
		.cfg     (cfg),
		.trigger (trigger),
		.ticks   (ticks),
		.volume  (volume)
	);

	ch1_output u_out (
		.clk            (clk),
		.rst            (rst),
		.cfg            (cfg),
		.trigger        (trigger),
		.length_load    (length_load),
		.ticks          (ticks),
		.duty_bit       (duty_bit),
		.volume         (volume),
		.sweep_overflow (sweep_overflow),
		.sample         (sample),
		.ch1_on         (ch1_on)
	);

endmodule

`default_nettype wire

// ==== hw/ch1_output.sv ====
`timescale 1ns/1ns
`default_nettype none

module ch1_output (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire apu_pkg::ch1_cfg_t    cfg,
	input  wire logic                 trigger,
	input  wire logic                 length_load,
	input  wire apu_pkg::frame_tick_t ticks,
	input  wire logic                 duty_bit,
	input  wire logic [3:0]           volume,
	input  wire logic                 sweep_overflow,
	output logic [3:0]                sample,
	output logic                      ch1_on
);

	logic [6:0] len_cnt; // 64 minus load, 0 means expired
	logic       len_expired;
	logic       on_next;

	assign len_expired = cfg.length_en && len_cnt == 7'd0;

	always_comb begin
		on_next = ch1_on;
		if (!cfg.dac_en)
			on_next = 1'b0;
		else if (trigger)
			on_next = !sweep_overflow;
		else if (sweep_overflow || len_expired)
			on_next = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			len_cnt <= '0;
		end else if (length_load) begin
			len_cnt <= 7'd64 - {1'b0, cfg.length_load};
		end else if (trigger && len_cnt == 7'd0) begin
			len_cnt <= 7'd64; // retrigger after expiry runs full length
		end else if (ticks.length && cfg.length_en && len_cnt != 7'd0) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

	// gate with next state so sample and ch1_on drop together
	always_ff @(posedge clk) begin
		if (rst) begin
			ch1_on <= 1'b0;
			sample <= '0;
		end else begin
			ch1_on <= on_next;
			sample <= (duty_bit && on_next) ? volume : 4'h0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ch1_envelope.sv ====
`timescale 1ns/1ns
`default_nettype none

module ch1_envelope (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire apu_pkg::ch1_cfg_t    cfg,
	input  wire logic                 trigger,
	input  wire apu_pkg::frame_tick_t ticks,
	output logic [3:0]                volume
);

	logic [2:0] env_period; // latched on trigger
	logic [2:0] env_cnt;
	logic       env_inc;
	logic       at_limit;

	assign at_limit = env_inc ? volume == 4'hf : volume == 4'h0;

	always_ff @(posedge clk) begin
		if (rst) begin
			volume     <= '0;
			env_period <= '0;
			env_cnt    <= '0;
			env_inc    <= 1'b0;
		end else if (trigger) begin
			volume     <= cfg.env.init_vol;
			env_period <= cfg.env.period;
			env_cnt    <= cfg.env.period;
			env_inc    <= cfg.env.increase;
		end else if (ticks.envelope && env_period != 3'd0) begin // period 0 holds volume
			if (env_cnt <= 3'd1) begin
				env_cnt <= env_period;
				if (!at_limit)
					volume <= env_inc ? volume + 1'b1 : volume - 1'b1;
			end else begin
				env_cnt <= env_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/ch1_freq_sweep.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apu_settings.svh"

module ch1_freq_sweep (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire apu_pkg::ch1_cfg_t    cfg,
	input  wire logic                 trigger,
	input  wire apu_pkg::frame_tick_t ticks,
	output logic                      duty_bit,
	output logic                      sweep_overflow
);

	localparam int PRE_W = $clog2(`APU_FREQ_PRESCALE + 1);

	logic [PRE_W-1:0] pre_cnt;
	logic             pre_wrap;
	logic [11:0]      timer;      // 1 to 2048 prescaled ticks
	logic [10:0]      shadow;
	logic [2:0]       duty_step;
	logic [2:0]       sweep_cnt;
	logic [10:0]      calc_base;
	logic [10:0]      calc_delta;
	logic [11:0]      calc_sum;
	logic             sweep_step;
	logic [7:0]       pattern;

	assign pre_wrap = pre_cnt == PRE_W'(`APU_FREQ_PRESCALE - 1);

	// trigger checks against the fresh register value
	assign calc_base  = trigger ? cfg.freq : shadow;
	assign calc_delta = calc_base >> cfg.sweep.shift;
	assign calc_sum   = cfg.sweep.decrease ? {1'b0, calc_base} - {1'b0, calc_delta}
	                                       : {1'b0, calc_base} + {1'b0, calc_delta};

	assign sweep_step = ticks.sweep && sweep_cnt <= 3'd1 && cfg.sweep.period != 3'd0;

	// bit 11 only sets on an increase past 2047
	assign sweep_overflow = (trigger || sweep_step) && cfg.sweep.shift != 3'd0 && calc_sum[11];

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt   <= '0;
			timer     <= 12'd2048;
			shadow    <= '0;
			duty_step <= '0;
			sweep_cnt <= '0;
		end else if (trigger) begin
			pre_cnt   <= '0;
			shadow    <= cfg.freq;
			timer     <= 12'd2048 - {1'b0, cfg.freq};
			sweep_cnt <= cfg.sweep.period;
		end else begin
			pre_cnt <= pre_wrap ? '0 : pre_cnt + 1'b1;
			if (pre_wrap) begin
				if (timer <= 12'd1) begin
					timer     <= 12'd2048 - {1'b0, shadow};
					duty_step <= duty_step + 1'b1;
				end else begin
					timer <= timer - 1'b1;
				end
			end
			if (ticks.sweep) begin
				if (sweep_cnt <= 3'd1)
					sweep_cnt <= cfg.sweep.period;
				else
					sweep_cnt <= sweep_cnt - 1'b1;
			end
			if (sweep_step && cfg.sweep.shift != 3'd0 && !calc_sum[11])
				shadow <= calc_sum[10:0]; // new period used at next reload
		end
	end

	always_comb begin
		case (cfg.duty)
			2'd0:    pattern = 8'b0000_0001; // 12.5%
			2'd1:    pattern = 8'b1000_0001; // 25%
			2'd2:    pattern = 8'b1000_0111; // 50%
			default: pattern = 8'b0111_1110; // 75%
		endcase
	end

	assign duty_bit = pattern[duty_step];

endmodule

`default_nettype wire

// ==== hw/apu_frame_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apu_settings.svh"

module apu_frame_seq (
	input  wire logic          clk,
	input  wire logic          rst,
	output apu_pkg::frame_tick_t ticks
);

	localparam int DIV_W = $clog2(`APU_FRAME_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       step;
	logic             div_wrap;

	assign div_wrap = div_cnt == DIV_W'(`APU_FRAME_DIV - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			step    <= '0;
			ticks   <= '0;
		end else begin
			div_cnt        <= div_wrap ? '0 : div_cnt + 1'b1;
			ticks.length   <= div_wrap && !step[0];                   // steps 0,2,4,6
			ticks.sweep    <= div_wrap && (step == 3'd2 || step == 3'd6);
			ticks.envelope <= div_wrap && step == 3'd7;
			if (div_wrap)
				step <= step + 1'b1; // wraps after step 7
		end
	end

endmodule

`default_nettype wire

// ==== hw/ch1_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apu_settings.svh"

module ch1_regs (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire apu_pkg::apb_req_t apb_req,
	output apu_pkg::apb_rsp_t      apb_rsp,
	output apu_pkg::ch1_cfg_t      cfg,
	output logic                   trigger,
	output logic                   length_load
);

	apu_pkg::sweep_cfg_t nr10;
	logic [1:0]          nr11_duty;
	logic [5:0]          nr11_len;
	apu_pkg::env_cfg_t   nr12;
	logic [7:0]          nr13;
	logic                nr14_len_en;
	logic [2:0]          nr14_freq_hi;

	logic       access;
	logic       addr_ok;
	logic       wr_en;
	logic [7:0] rdata;

	assign access  = apb_req.psel && apb_req.penable;
	assign addr_ok = apb_req.paddr <= `APU_ADDR_NR14;
	assign wr_en   = access && apb_req.pwrite && addr_ok; // unmapped writes dropped

	// register writes land at the end of the access phase
	always_ff @(posedge clk) begin
		if (rst) begin
			nr10         <= '0;
			nr11_duty    <= '0;
			nr11_len     <= '0;
			nr12         <= '0;
			nr13         <= '0;
			nr14_len_en  <= 1'b0;
			nr14_freq_hi <= '0;
		end else if (wr_en) begin
			case (apb_req.paddr)
				`APU_ADDR_NR10: nr10 <= apu_pkg::sweep_cfg_t'(apb_req.pwdata[6:0]);
				`APU_ADDR_NR11: begin
					nr11_duty <= apb_req.pwdata[7:6];
					nr11_len  <= apb_req.pwdata[5:0];
				end
				`APU_ADDR_NR12: nr12 <= apu_pkg::env_cfg_t'(apb_req.pwdata);
				`APU_ADDR_NR13: nr13 <= apb_req.pwdata;
				`APU_ADDR_NR14: begin
					nr14_len_en  <= apb_req.pwdata[6];
					nr14_freq_hi <= apb_req.pwdata[2:0];
				end
				default: ;
			endcase
		end
	end

	// one-cycle strobes, the cycle after the write
	always_ff @(posedge clk) begin
		if (rst) begin
			trigger     <= 1'b0;
			length_load <= 1'b0;
		end else begin
			trigger     <= wr_en && apb_req.paddr == `APU_ADDR_NR14 && apb_req.pwdata[7];
			length_load <= wr_en && apb_req.paddr == `APU_ADDR_NR11;
		end
	end

	// write-only bits read back as ones
	always_comb begin
		case (apb_req.paddr)
			`APU_ADDR_NR10: rdata = {1'b1, nr10};
			`APU_ADDR_NR11: rdata = {nr11_duty, 6'h3f}; // length is write only
			`APU_ADDR_NR12: rdata = nr12;
			`APU_ADDR_NR13: rdata = 8'hff;
			`APU_ADDR_NR14: rdata = {1'b1, nr14_len_en, 6'h3f};
			default:        rdata = 8'h00;
		endcase
	end

	assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 8'h00;
	assign apb_rsp.pready  = access; // no wait states
	assign apb_rsp.pslverr = access && !addr_ok;

	assign cfg = '{
		sweep:       nr10,
		duty:        nr11_duty,
		length_load: nr11_len,
		env:         nr12,
		freq:        {nr14_freq_hi, nr13},
		length_en:   nr14_len_en,
		dac_en:      |{nr12.init_vol, nr12.increase} // upper five bits of NR12
	};

endmodule

`default_nettype wire

// ==== hw/apu_pkg.sv ====
`default_nettype none

package apu_pkg;

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		logic [2:0] paddr;
		logic [7:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
		logic       pslverr;
	} apb_rsp_t;

	// bit order matches NR10[6:0]
	typedef struct packed {
		logic [2:0] period;
		logic       decrease;
		logic [2:0] shift;
	} sweep_cfg_t;

	// bit order matches NR12[7:0]
	typedef struct packed {
		logic [3:0] init_vol;
		logic       increase;
		logic [2:0] period;
	} env_cfg_t;

	typedef struct packed {
		sweep_cfg_t  sweep;
		logic [1:0]  duty;
		logic [5:0]  length_load;
		env_cfg_t    env;
		logic [10:0] freq;
		logic        length_en;
		logic        dac_en;
	} ch1_cfg_t;

	typedef struct packed {
		logic length;
		logic sweep;
		logic envelope;
	} frame_tick_t;

endpackage

`default_nettype wire

// ==== hw/apu_settings.svh ====
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// register offsets inside the channel 1 window
`define APU_ADDR_NR10 3'd0
`define APU_ADDR_NR11 3'd1
`define APU_ADDR_NR12 3'd2
`define APU_ADDR_NR13 3'd3
`define APU_ADDR_NR14 3'd4

// clocks per frequency timer tick
`define APU_FREQ_PRESCALE 4

// clocks per frame sequencer step, 8192 on silicon
`define APU_FRAME_DIV 32

`endif
